//--- axi_mmu_top.f
+incdir+include
src/axi_mmu_pkg.sv
src/mmu_xlate_pkg.sv
src/addr_queue.sv
src/addr_ch_xlate.sv
src/xlate_arbiter.sv
src/axi_mmu_top.sv
verif/axi_mmu_assert.sv
verif/axi_mmu_tb.sv

//--- Bender.yml
package:
  name: axi_mmu

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/axi_mmu_pkg.sv
      - src/mmu_xlate_pkg.sv
      - src/addr_queue.sv
      - src/addr_ch_xlate.sv
      - src/xlate_arbiter.sv
      - src/axi_mmu_top.sv
  - target: test
    files:
      - verif/axi_mmu_assert.sv
      - verif/axi_mmu_tb.sv

//--- verif/axi_mmu_tb.sv
`timescale 1ns/10ps

module axi_mmu_tb;

    // One slave-side beat per row.
    typedef struct packed {
        logic        is_wr;
        logic [7:0]  id;
        logic [31:0] vaddr;
        logic [7:0]  len;
        logic [2:0]  size;
    } stim_t;

    typedef struct packed {
        logic [7:0]  id;
        logic [31:0] addr;
        logic [7:0]  len;
        logic [2:0]  size;
    } exp_beat_t;

    localparam int N_STIM       = 16;
    localparam int CYCLE_LIMIT  = 200 * N_STIM;
    localparam int STALL_CYCLES = 60;          // Master ready held low at start.

    // Pages ending in F are dropped by the translator model.
    stim_t stim_table [N_STIM] = '{
        '{1'b1, 8'h01, 32'h0001_2345, 8'd0,  3'd2},
        '{1'b0, 8'h81, 32'h0002_0100, 8'd3,  3'd3},
        '{1'b1, 8'h02, 32'h1234_5678, 8'd7,  3'd2},
        '{1'b0, 8'h82, 32'h3333_3333, 8'd0,  3'd0},
        '{1'b1, 8'h03, 32'h0000_F00C, 8'd1,  3'd1},
        '{1'b0, 8'h83, 32'h5555_F555, 8'd15, 3'd2},
        '{1'b1, 8'h04, 32'hABCD_E010, 8'd15, 3'd3},
        '{1'b0, 8'h84, 32'h0F0F_0F0F, 8'd2,  3'd1},
        '{1'b1, 8'h05, 32'h7777_7FFC, 8'd0,  3'd2},
        '{1'b0, 8'h85, 32'hDEAD_BEEF, 8'd255, 3'd0},
        '{1'b1, 8'h06, 32'h0010_F800, 8'd4,  3'd2},
        '{1'b0, 8'h86, 32'h0000_1FFF, 8'd1,  3'd2},
        '{1'b1, 8'h07, 32'hFFFF_E000, 8'd3,  3'd3},
        '{1'b0, 8'h87, 32'hCAFE_F123, 8'd0,  3'd1},
        '{1'b1, 8'h08, 32'h8000_0004, 8'd127, 3'd2},
        '{1'b0, 8'h88, 32'h2468_ACE0, 8'd5,  3'd3}
    };

    logic                    s_axi_clk;
    logic                    arst_n;
    axi_mmu_pkg::axi_id_t    s_axi_awid, s_axi_arid, m_axi_awid, m_axi_arid;
    axi_mmu_pkg::axi_addr_t  s_axi_awaddr, s_axi_araddr, m_axi_awaddr, m_axi_araddr;
    axi_mmu_pkg::axi_len_t   s_axi_awlen, s_axi_arlen, m_axi_awlen, m_axi_arlen;
    axi_mmu_pkg::axi_size_t  s_axi_awsize, s_axi_arsize, m_axi_awsize, m_axi_arsize;
    axi_mmu_pkg::axi_burst_t s_axi_awburst, s_axi_arburst, m_axi_awburst, m_axi_arburst;
    logic                    s_axi_awvalid, s_axi_awready, s_axi_arvalid, s_axi_arready;
    logic                    m_axi_awvalid, m_axi_awready, m_axi_arvalid, m_axi_arready;
    logic                    xlate_req, xlate_is_write, xlate_ack, xlate_drop;
    mmu_xlate_pkg::vpn_t     xlate_vpn;
    mmu_xlate_pkg::ppn_t     xlate_ppn;

    exp_beat_t           exp_aw_q [$];
    exp_beat_t           exp_ar_q [$];
    mmu_xlate_pkg::vpn_t wr_vpn_q [$];    // Pages in translation order, drops included.
    mmu_xlate_pkg::vpn_t rd_vpn_q [$];
    int                  error_cnt;
    int                  checked_cnt;
    int                  cycle_cnt;
    logic                hold_ready_low;

    axi_mmu_top axi_mmu_top_i (.*);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Translator model and reference rules.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic mmu_xlate_pkg::ppn_t model_ppn(input mmu_xlate_pkg::vpn_t vpn);
        return vpn ^ mmu_xlate_pkg::ppn_t'(8'hFF);     // Low 8 bits inverted.
    endfunction

    function automatic logic model_drop(input mmu_xlate_pkg::vpn_t vpn);
        return (vpn[3:0] == 4'hF);
    endfunction

    initial begin : translator_model
        int unsigned delay;
        xlate_ack  = 1'b0;
        xlate_ppn  = '0;
        xlate_drop = 1'b0;
        forever begin
            @(posedge s_axi_clk);
            #1;
            if (xlate_req) begin
                match_xlate_request();
                delay = $urandom_range(1, 4);
                repeat (delay - 1) begin
                    @(posedge s_axi_clk);
                    #1;
                end
                xlate_ppn  = model_ppn(xlate_vpn);
                xlate_drop = model_drop(xlate_vpn);
                xlate_ack  = 1'b1;
                while (xlate_req) begin                 // Phase 3.
                    @(posedge s_axi_clk);
                    #1;
                end
                xlate_ack = 1'b0;
            end
        end
    end

    initial begin : clock_gen
        s_axi_clk = 1'b0;
        forever begin
            #5 s_axi_clk = ~s_axi_clk;
        end
    end

    initial begin : ready_driver
        m_axi_awready = 1'b0;
        m_axi_arready = 1'b0;
        forever begin
            @(posedge s_axi_clk);
            #1;
            m_axi_awready = !hold_ready_low && ($urandom_range(0, 3) != 0);
            m_axi_arready = !hold_ready_low && ($urandom_range(0, 3) != 0);
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Slave-side stimulus.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic drive_slave(input logic is_wr, input logic valid, input stim_t e);
        if (is_wr) begin
            s_axi_awvalid = valid;
            s_axi_awid    = e.id;
            s_axi_awaddr  = e.vaddr;
            s_axi_awlen   = e.len;
            s_axi_awsize  = e.size;
        end else begin
            s_axi_arvalid = valid;
            s_axi_arid    = e.id;
            s_axi_araddr  = e.vaddr;
            s_axi_arlen   = e.len;
            s_axi_arsize  = e.size;
        end
    endtask

    task automatic send_channel(input logic is_wr);
        stim_t     e;
        exp_beat_t exp;
        logic      accepted;
        for (int i = 0; i < N_STIM; i++) begin
            e = stim_table[i];
            if (e.is_wr == is_wr) begin
                exp.id   = e.id;
                exp.addr = {model_ppn(e.vaddr[31:12]), e.vaddr[11:0]};   // 4 KiB pages.
                exp.len  = e.len;
                exp.size = e.size;
                if (is_wr) begin
                    wr_vpn_q.push_back(e.vaddr[31:12]);
                end else begin
                    rd_vpn_q.push_back(e.vaddr[31:12]);
                end
                if (!model_drop(e.vaddr[31:12])) begin
                    if (is_wr) begin
                        exp_aw_q.push_back(exp);
                    end else begin
                        exp_ar_q.push_back(exp);
                    end
                end
                drive_slave(is_wr, 1'b1, e);
                accepted = 1'b0;
                while (!accepted) begin
                    @(negedge s_axi_clk);
                    accepted = is_wr ? s_axi_awready : s_axi_arready;
                    @(posedge s_axi_clk);
                    #1;
                end
                drive_slave(is_wr, 1'b0, e);
                repeat ($urandom_range(0, 2)) begin
                    @(posedge s_axi_clk);
                    #1;
                end
            end
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic check_reset_state(input string stage_name);
        if (m_axi_awvalid !== 1'b0 || m_axi_arvalid !== 1'b0 || xlate_req !== 1'b0) begin
            $display("FAILED at %0t: master valid or xlate_req not low %s", $time, stage_name);
            error_cnt++;
        end
        if (s_axi_awready !== 1'b1 || s_axi_arready !== 1'b1) begin
            $display("FAILED at %0t: slave ready not high %s", $time, stage_name);
            error_cnt++;
        end
    endtask

    // Requester and page of each translation follow that channel's table order.
    task automatic match_xlate_request();
        mmu_xlate_pkg::vpn_t exp_vpn;
        string               ch;
        ch = xlate_is_write ? "AW" : "AR";
        if ((xlate_is_write && wr_vpn_q.size() == 0) ||
            (!xlate_is_write && rd_vpn_q.size() == 0)) begin
            $display("Translation request for %s page %h at %0t, no %s beat was waiting",
                     ch, xlate_vpn, $time, ch);
            error_cnt++;
            return;
        end
        if (xlate_is_write) begin
            exp_vpn = wr_vpn_q.pop_front();
        end else begin
            exp_vpn = rd_vpn_q.pop_front();
        end
        if (xlate_vpn !== exp_vpn) begin
            $display("FAILED at %0t: %s translation request for page %h, expected %h",
                     $time, ch, xlate_vpn, exp_vpn);
            error_cnt++;
        end
    endtask

    task automatic check_beat(input logic is_wr, input exp_beat_t got,
                              input axi_mmu_pkg::axi_burst_t burst);
        exp_beat_t exp;
        string     ch;
        ch = is_wr ? "AW" : "AR";
        if ((is_wr && exp_aw_q.size() == 0) || (!is_wr && exp_ar_q.size() == 0)) begin
            $display("Unexpected %s beat at %0t with id %h and address %h, none was pending",
                     ch, $time, got.id, got.addr);
            error_cnt++;
            return;
        end
        if (is_wr) begin
            exp = exp_aw_q.pop_front();
        end else begin
            exp = exp_ar_q.pop_front();
        end
        checked_cnt++;
        if (got.addr !== exp.addr) begin
            $display("FAILED at %0t: %s address %h, expected %h", $time, ch, got.addr, exp.addr);
            error_cnt++;
        end
        if (got.id !== exp.id || got.len !== exp.len || got.size !== exp.size) begin
            $display("FAILED at %0t: %s id/len/size %h/%h/%h, expected %h/%h/%h", $time, ch,
                     got.id, got.len, got.size, exp.id, exp.len, exp.size);
            error_cnt++;
        end
        if (burst !== axi_mmu_pkg::INCR) begin
            $display("FAILED at %0t: %s burst %0d, expected INCR", $time, ch, burst);
            error_cnt++;
        end
    endtask

    // Valid and ready are both stable at the falling edge.
    always @(negedge s_axi_clk) begin
        if (arst_n && m_axi_awvalid && m_axi_awready) begin
            check_beat(1'b1, {m_axi_awid, m_axi_awaddr, m_axi_awlen, m_axi_awsize}, m_axi_awburst);
        end
        if (arst_n && m_axi_arvalid && m_axi_arready) begin
            check_beat(1'b0, {m_axi_arid, m_axi_araddr, m_axi_arlen, m_axi_arsize}, m_axi_arburst);
        end
    end

    initial begin : cycle_limit
        cycle_cnt = 0;
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge s_axi_clk);
            cycle_cnt++;
        end
        $display("Timeout after %0d cycles, %0d AW and %0d AR beats never arrived",
                 cycle_cnt, exp_aw_q.size(), exp_ar_q.size());
        $display(">>> FAIL");
        $finish;
    end

    initial begin : main_seq
        int total_err;
        void'($urandom(98));
        error_cnt      = 0;
        checked_cnt    = 0;
        hold_ready_low = 1'b1;
        arst_n         = 1'b0;
        drive_slave(1'b1, 1'b0, '0);
        drive_slave(1'b0, 1'b0, '0);
        s_axi_awburst = axi_mmu_pkg::INCR;
        s_axi_arburst = axi_mmu_pkg::INCR;
        repeat (10) begin
            @(posedge s_axi_clk);
            #1;
            check_reset_state("during reset");
        end
        arst_n = 1'b1;
        @(posedge s_axi_clk);
        #1;
        check_reset_state("after reset");
        fork
            send_channel(1'b1);
            send_channel(1'b0);
            begin
                repeat (STALL_CYCLES) @(posedge s_axi_clk);
                hold_ready_low = 1'b0;
            end
        join
        while (exp_aw_q.size() != 0 || exp_ar_q.size() != 0) begin
            @(posedge s_axi_clk);
        end
        repeat (20) @(posedge s_axi_clk);                    // Catch stray beats.
        total_err = error_cnt + axi_mmu_top_i.u_assert.fail_count;
        $display("Checked %0d beats, %0d check errors, %0d assertion failures",
                 checked_cnt, error_cnt, axi_mmu_top_i.u_assert.fail_count);
        if (total_err == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- verif/axi_mmu_assert.sv
`timescale 1ns/10ps

module axi_mmu_assert (
    input logic                   s_axi_clk,
    input logic                   arst_n,
    input logic                   xlate_req,
    input logic                   xlate_ack,
    input logic                   m_axi_awvalid,
    input logic                   m_axi_awready,
    input axi_mmu_pkg::axi_id_t   m_axi_awid,
    input axi_mmu_pkg::axi_addr_t m_axi_awaddr,
    input logic                   m_axi_arvalid,
    input logic                   m_axi_arready,
    input axi_mmu_pkg::axi_id_t   m_axi_arid,
    input axi_mmu_pkg::axi_addr_t m_axi_araddr
);

    int fail_count = 0;

    // Four-phase translator handshake.
    req_held: assert property (@(posedge s_axi_clk) disable iff (!arst_n)
        $fell(xlate_req) |-> $past(xlate_ack))
        else begin
            $error("xlate_req fell before xlate_ack was high");
            fail_count++;
        end

    req_after_ack_low: assert property (@(posedge s_axi_clk) disable iff (!arst_n)
        $rose(xlate_req) |-> !$past(xlate_ack))
        else begin
            $error("xlate_req rose while xlate_ack was high");
            fail_count++;
        end

    // Master side holds a stalled beat.
    aw_stable: assert property (@(posedge s_axi_clk) disable iff (!arst_n)
        m_axi_awvalid && !m_axi_awready |=>
            m_axi_awvalid && $stable(m_axi_awaddr) && $stable(m_axi_awid))
        else begin
            $error("AW beat changed or vanished before ready");
            fail_count++;
        end

    ar_stable: assert property (@(posedge s_axi_clk) disable iff (!arst_n)
        m_axi_arvalid && !m_axi_arready |=>
            m_axi_arvalid && $stable(m_axi_araddr) && $stable(m_axi_arid))
        else begin
            $error("AR beat changed or vanished before ready");
            fail_count++;
        end

endmodule

bind axi_mmu_top axi_mmu_assert u_assert (
    .s_axi_clk     (s_axi_clk),
    .arst_n        (arst_n),
    .xlate_req     (xlate_req),
    .xlate_ack     (xlate_ack),
    .m_axi_awvalid (m_axi_awvalid),
    .m_axi_awready (m_axi_awready),
    .m_axi_awid    (m_axi_awid),
    .m_axi_awaddr  (m_axi_awaddr),
    .m_axi_arvalid (m_axi_arvalid),
    .m_axi_arready (m_axi_arready),
    .m_axi_arid    (m_axi_arid),
    .m_axi_araddr  (m_axi_araddr)
);

//--- src/axi_mmu_top.sv
`timescale 1ns/10ps

module axi_mmu_top (
    input  logic                    s_axi_clk,
    input  logic                    arst_n,
    // Slave write address.
    input  axi_mmu_pkg::axi_id_t    s_axi_awid,
    input  axi_mmu_pkg::axi_addr_t  s_axi_awaddr,
    input  axi_mmu_pkg::axi_len_t   s_axi_awlen,
    input  axi_mmu_pkg::axi_size_t  s_axi_awsize,
    input  axi_mmu_pkg::axi_burst_t s_axi_awburst,
    input  logic                    s_axi_awvalid,
    output logic                    s_axi_awready,
    // Slave read address.
    input  axi_mmu_pkg::axi_id_t    s_axi_arid,
    input  axi_mmu_pkg::axi_addr_t  s_axi_araddr,
    input  axi_mmu_pkg::axi_len_t   s_axi_arlen,
    input  axi_mmu_pkg::axi_size_t  s_axi_arsize,
    input  axi_mmu_pkg::axi_burst_t s_axi_arburst,
    input  logic                    s_axi_arvalid,
    output logic                    s_axi_arready,
    // Master write address.
    output axi_mmu_pkg::axi_id_t    m_axi_awid,
    output axi_mmu_pkg::axi_addr_t  m_axi_awaddr,
    output axi_mmu_pkg::axi_len_t   m_axi_awlen,
    output axi_mmu_pkg::axi_size_t  m_axi_awsize,
    output axi_mmu_pkg::axi_burst_t m_axi_awburst,
    output logic                    m_axi_awvalid,
    input  logic                    m_axi_awready,
    // Master read address.
    output axi_mmu_pkg::axi_id_t    m_axi_arid,
    output axi_mmu_pkg::axi_addr_t  m_axi_araddr,
    output axi_mmu_pkg::axi_len_t   m_axi_arlen,
    output axi_mmu_pkg::axi_size_t  m_axi_arsize,
    output axi_mmu_pkg::axi_burst_t m_axi_arburst,
    output logic                    m_axi_arvalid,
    input  logic                    m_axi_arready,
    // Translator.
    output logic                    xlate_req,
    output mmu_xlate_pkg::vpn_t     xlate_vpn,
    output logic                    xlate_is_write,
    input  logic                    xlate_ack,
    input  mmu_xlate_pkg::ppn_t     xlate_ppn,
    input  logic                    xlate_drop
);

    logic                wr_tr_req;
    mmu_xlate_pkg::vpn_t wr_tr_vpn;
    logic                wr_done;
    logic                rd_tr_req;
    mmu_xlate_pkg::vpn_t rd_tr_vpn;
    logic                rd_done;
    mmu_xlate_pkg::ppn_t res_ppn;   // Shared result, qualified by done.
    logic                res_drop;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Address channels.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    addr_ch_xlate u_wr_ch (
        .s_axi_clk (s_axi_clk),
        .arst_n    (arst_n),
        .s_id      (s_axi_awid),
        .s_addr    (s_axi_awaddr),
        .s_len     (s_axi_awlen),
        .s_size    (s_axi_awsize),
        .s_burst   (s_axi_awburst),
        .s_valid   (s_axi_awvalid),
        .s_ready   (s_axi_awready),
        .tr_req    (wr_tr_req),
        .tr_vpn    (wr_tr_vpn),
        .tr_done   (wr_done),
        .tr_ppn    (res_ppn),
        .tr_drop   (res_drop),
        .m_id      (m_axi_awid),
        .m_addr    (m_axi_awaddr),
        .m_len     (m_axi_awlen),
        .m_size    (m_axi_awsize),
        .m_burst   (m_axi_awburst),
        .m_valid   (m_axi_awvalid),
        .m_ready   (m_axi_awready)
    );

    addr_ch_xlate u_rd_ch (
        .s_axi_clk (s_axi_clk),
        .arst_n    (arst_n),
        .s_id      (s_axi_arid),
        .s_addr    (s_axi_araddr),
        .s_len     (s_axi_arlen),
        .s_size    (s_axi_arsize),
        .s_burst   (s_axi_arburst),
        .s_valid   (s_axi_arvalid),
        .s_ready   (s_axi_arready),
        .tr_req    (rd_tr_req),
        .tr_vpn    (rd_tr_vpn),
        .tr_done   (rd_done),
        .tr_ppn    (res_ppn),
        .tr_drop   (res_drop),
        .m_id      (m_axi_arid),
        .m_addr    (m_axi_araddr),
        .m_len     (m_axi_arlen),
        .m_size    (m_axi_arsize),
        .m_burst   (m_axi_arburst),
        .m_valid   (m_axi_arvalid),
        .m_ready   (m_axi_arready)
    );

    // One translator for both channels.
    xlate_arbiter u_arb (
        .s_axi_clk      (s_axi_clk),
        .arst_n         (arst_n),
        .wr_req         (wr_tr_req),
        .wr_vpn         (wr_tr_vpn),
        .rd_req         (rd_tr_req),
        .rd_vpn         (rd_tr_vpn),
        .wr_done        (wr_done),
        .rd_done        (rd_done),
        .res_ppn        (res_ppn),
        .res_drop       (res_drop),
        .xlate_req      (xlate_req),
        .xlate_vpn      (xlate_vpn),
        .xlate_is_write (xlate_is_write),
        .xlate_ack      (xlate_ack),
        .xlate_ppn      (xlate_ppn),
        .xlate_drop     (xlate_drop)
    );

endmodule

//--- src/xlate_arbiter.sv
`timescale 1ns/10ps

module xlate_arbiter (
    input  logic                s_axi_clk,
    input  logic                arst_n,
    // Channel requesters.
    input  logic                wr_req,
    input  mmu_xlate_pkg::vpn_t wr_vpn,
    input  logic                rd_req,
    input  mmu_xlate_pkg::vpn_t rd_vpn,
    output logic                wr_done,
    output logic                rd_done,
    output mmu_xlate_pkg::ppn_t res_ppn,
    output logic                res_drop,
    // External translator, four-phase.
    output logic                xlate_req,
    output mmu_xlate_pkg::vpn_t xlate_vpn,
    output logic                xlate_is_write,
    input  logic                xlate_ack,
    input  mmu_xlate_pkg::ppn_t xlate_ppn,
    input  logic                xlate_drop
);

    typedef enum logic [1:0] {
        IDLE,
        REQ,
        RELEASE,
        WAIT_ACK_LOW
    } arb_state_e;

    arb_state_e                 state;
    mmu_xlate_pkg::xlate_chan_e grant_chan;   // Also the last grant.
    mmu_xlate_pkg::xlate_chan_e next_chan;
    logic                       grant;
    logic                       capture;
    logic                       done_r;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Round-robin pick.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        if (wr_req && rd_req) begin
            if (grant_chan == mmu_xlate_pkg::CHAN_WR) begin
                next_chan = mmu_xlate_pkg::CHAN_RD;
            end else begin
                next_chan = mmu_xlate_pkg::CHAN_WR;
            end
        end else if (wr_req) begin
            next_chan = mmu_xlate_pkg::CHAN_WR;
        end else begin
            next_chan = mmu_xlate_pkg::CHAN_RD;
        end
    end

    // Grant only once the previous ack has dropped.
    assign grant   = (state == IDLE) && !xlate_ack && (wr_req || rd_req);
    assign capture = (state == REQ) && xlate_ack;

    always_ff @(posedge s_axi_clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= IDLE;
            grant_chan <= mmu_xlate_pkg::CHAN_RD;  // Write wins first tie.
            xlate_req  <= 1'b0;
            done_r     <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (grant) begin
                        grant_chan <= next_chan;
                        xlate_req  <= 1'b1;
                        state      <= REQ;
                    end
                end
                REQ: begin
                    if (capture) begin
                        xlate_req <= 1'b0;
                        done_r    <= 1'b1;
                        state     <= RELEASE;
                    end
                end
                RELEASE: begin                     // Done pulse is out.
                    done_r <= 1'b0;
                    state  <= WAIT_ACK_LOW;
                end
                WAIT_ACK_LOW: begin
                    if (!xlate_ack) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge s_axi_clk) begin
        if (grant) begin
            xlate_vpn <= (next_chan == mmu_xlate_pkg::CHAN_WR) ? wr_vpn : rd_vpn;
        end
        if (capture) begin
            res_ppn  <= xlate_ppn;
            res_drop <= xlate_drop;
        end
    end

    assign xlate_is_write = (grant_chan == mmu_xlate_pkg::CHAN_WR);
    assign wr_done        = done_r && (grant_chan == mmu_xlate_pkg::CHAN_WR);
    assign rd_done        = done_r && (grant_chan == mmu_xlate_pkg::CHAN_RD);

endmodule

//--- src/addr_ch_xlate.sv
`timescale 1ns/10ps

`include "mmu_consts.svh"

module addr_ch_xlate (
    input  logic                    s_axi_clk,
    input  logic                    arst_n,
    // Slave side.
    input  axi_mmu_pkg::axi_id_t    s_id,
    input  axi_mmu_pkg::axi_addr_t  s_addr,
    input  axi_mmu_pkg::axi_len_t   s_len,
    input  axi_mmu_pkg::axi_size_t  s_size,
    input  axi_mmu_pkg::axi_burst_t s_burst,
    input  logic                    s_valid,
    output logic                    s_ready,
    // Translation request to the arbiter.
    output logic                    tr_req,
    output mmu_xlate_pkg::vpn_t     tr_vpn,
    input  logic                    tr_done,
    input  mmu_xlate_pkg::ppn_t     tr_ppn,
    input  logic                    tr_drop,
    // Master side.
    output axi_mmu_pkg::axi_id_t    m_id,
    output axi_mmu_pkg::axi_addr_t  m_addr,
    output axi_mmu_pkg::axi_len_t   m_len,
    output axi_mmu_pkg::axi_size_t  m_size,
    output axi_mmu_pkg::axi_burst_t m_burst,
    output logic                    m_valid,
    input  logic                    m_ready
);

    axi_mmu_pkg::addr_beat_t   s_beat;
    axi_mmu_pkg::addr_beat_t   q_head;
    axi_mmu_pkg::addr_beat_t   xl_beat;
    axi_mmu_pkg::addr_beat_t   m_beat;
    mmu_xlate_pkg::page_ofs_t  head_ofs;
    logic                      q_push;
    logic                      q_full;
    logic                      q_empty;
    logic                      out_free;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Slave side into the queue.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        s_beat.id    = s_id;
        s_beat.addr  = s_addr;
        s_beat.len   = s_len;
        s_beat.size  = s_size;
        s_beat.burst = s_burst;
    end

    assign s_ready = !q_full;
    assign q_push  = s_valid && !q_full;

    addr_queue u_queue (
        .s_axi_clk (s_axi_clk),
        .arst_n    (arst_n),
        .push      (q_push),
        .push_beat (s_beat),
        .pop       (tr_done),       // Kept and dropped beats both leave.
        .head_beat (q_head),
        .full      (q_full),
        .empty     (q_empty)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Translation of the queue head.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign tr_vpn   = q_head.addr[`MMU_ADDR_W-1:`MMU_PAGE_OFS_W];
    assign head_ofs = q_head.addr[`MMU_PAGE_OFS_W-1:0];

    // Register is free now or is taken by the master this cycle.
    assign out_free = !m_valid || m_ready;

    always_ff @(posedge s_axi_clk or negedge arst_n) begin
        if (!arst_n) begin
            tr_req <= 1'b0;
        end else if (tr_done) begin
            tr_req <= 1'b0;
        end else if (!tr_req && !q_empty && out_free) begin
            tr_req <= 1'b1;
        end
    end

    // Physical page joined to the original offset.
    always_comb begin
        xl_beat      = q_head;
        xl_beat.addr = {tr_ppn, head_ofs};
    end

    always_ff @(posedge s_axi_clk) begin
        if (tr_done && !tr_drop) begin
            m_beat <= xl_beat;
        end
    end

    always_ff @(posedge s_axi_clk or negedge arst_n) begin
        if (!arst_n) begin
            m_valid <= 1'b0;
        end else if (tr_done && !tr_drop) begin
            m_valid <= 1'b1;
        end else if (m_ready) begin
            m_valid <= 1'b0;
        end
    end

    assign m_id    = m_beat.id;
    assign m_addr  = m_beat.addr;
    assign m_len   = m_beat.len;
    assign m_size  = m_beat.size;
    assign m_burst = m_beat.burst;

endmodule

//--- src/addr_queue.sv
`timescale 1ns/10ps

`include "mmu_consts.svh"

module addr_queue (
    input  logic                    s_axi_clk,
    input  logic                    arst_n,
    input  logic                    push,
    input  axi_mmu_pkg::addr_beat_t push_beat,
    input  logic                    pop,
    output axi_mmu_pkg::addr_beat_t head_beat,
    output logic                    full,
    output logic                    empty
);

    localparam int DEPTH = `MMU_AQ_DEPTH;
    localparam int PTR_W = `MMU_AQ_PTR_W;

    axi_mmu_pkg::addr_beat_t mem [DEPTH];
    logic [PTR_W-1:0]        wr_ptr;
    logic [PTR_W-1:0]        rd_ptr;
    logic [PTR_W:0]          count;     // One bit wider to hold DEPTH.
    logic                    do_push;
    logic                    do_pop;

    // Wrap at DEPTH, so depths that are not a power of two work too.
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign do_push   = push && !full;
    assign do_pop    = pop && !empty;
    assign full      = (count == (PTR_W + 1)'(DEPTH));
    assign empty     = (count == '0);
    assign head_beat = mem[rd_ptr];    // Valid only while not empty.

    always_ff @(posedge s_axi_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_beat;
        end
    end

    always_ff @(posedge s_axi_clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

//--- src/mmu_xlate_pkg.sv
package mmu_xlate_pkg;

`include "mmu_consts.svh"

    // Page number and offset split of an address.
    typedef logic [`MMU_ADDR_W-`MMU_PAGE_OFS_W-1:0] vpn_t;
    typedef logic [`MMU_ADDR_W-`MMU_PAGE_OFS_W-1:0] ppn_t;
    typedef logic [`MMU_PAGE_OFS_W-1:0]             page_ofs_t;

    // Requester of a translation.
    // The value is what the translator sees on xlate_is_write.
    typedef enum logic {
        CHAN_RD = 1'b0,
        CHAN_WR = 1'b1
    } xlate_chan_e;

endpackage

//--- src/axi_mmu_pkg.sv
package axi_mmu_pkg;

`include "mmu_consts.svh"

    // Plain AXI address channel fields.
    typedef logic [`MMU_ADDR_W-1:0] axi_addr_t;
    typedef logic [`MMU_ID_W-1:0]   axi_id_t;
    typedef logic [7:0]             axi_len_t;    // Beats minus one.
    typedef logic [2:0]             axi_size_t;   // Log2 of bytes per beat.

    // AXI burst encoding.
    typedef enum logic [1:0] {
        FIXED = 2'b00,
        INCR  = 2'b01,
        WRAP  = 2'b10
    } axi_burst_t;

    // One address beat as it sits in a channel queue.
    typedef struct packed {
        axi_id_t    id;
        axi_addr_t  addr;
        axi_len_t   len;
        axi_size_t  size;
        axi_burst_t burst;
    } addr_beat_t;

endpackage

//--- include/mmu_consts.svh
`ifndef MMU_CONSTS_SVH
`define MMU_CONSTS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Address channel widths.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define MMU_ADDR_W      32             // AXI address bits.
`define MMU_ID_W        8              // Transaction ID bits.

// 4 KiB pages.
`define MMU_PAGE_OFS_W  12

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Address queue sizing.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define MMU_AQ_DEPTH    4              // Beats waiting per channel.
`define MMU_AQ_PTR_W    $clog2(`MMU_AQ_DEPTH)

`endif
